// ==== src.f ====
+incdir+include
source/muldiv_types_pkg.sv
source/muldiv_op_pkg.sv
source/div_unit.sv
source/mul_unit.sv
source/muldiv_ctrl.sv
source/muldiv_top.sv
sim/muldiv_props.sv
sim/muldiv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the muldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module muldiv_tb -f src.f -o muldiv_sim
./obj_dir/muldiv_sim | tee sim.log

if grep -qx '>>> PASS' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== sim/muldiv_tb.sv ====
// testbench for muldiv_top with clock, reset, LFSR stimulus, reference model, compare tasks, timeout
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_tb
	import muldiv_types_pkg::*;
	import muldiv_op_pkg::*;
();

	localparam int N_TESTS      = 250;
	localparam int CYC_PER_TEST = 40;
	localparam int TIMEOUT_CYC  = N_TESTS * CYC_PER_TEST + 100;
	localparam int N_RANDOM     = 230;
	localparam int MUL_LAT      = 4;  // req rise to done
	localparam int DIV_LAT      = 36;
	localparam int DRIVE_DLY    = 10;

	typedef struct packed {
		md_op_e op;
		xlen_t  val;
		int     t0; // cycle count at request rise
	} exp_t;

	logic    clk_i;
	logic    rst_i;
	logic    req_i;
	md_req_t req_data_i;
	logic    done_o;
	xlen_t   result_o;

	logic [15:0] lfsr_q;
	int          cyc_cnt = 0;
	exp_t        exp_q[$];
	exp_t        chk_item;

	muldiv_top muldiv_top_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.req_i      (req_i),
		.req_data_i (req_data_i),
		.done_o     (done_o),
		.result_o   (result_o)
	);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= TIMEOUT_CYC) begin
			stop_with_fail($sformatf("timeout, the tests did not finish within %0d cycles",
				TIMEOUT_CYC));
		end
	end

	task automatic stop_with_fail(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end else begin
			return s >> 1;
		end
	endfunction

	function automatic xlen_t rand_bits(input int n);
		xlen_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[`MD_XLEN-2:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
		end
		return v;
	endfunction

	// expected result from the M-extension rules in 64-bit arithmetic
	function automatic xlen_t ref_muldiv(input md_op_e op, input xlen_t a, input xlen_t b);
		dword_t ax;
		dword_t bx;
		dword_t prod;
		longint sa;
		longint sb;
		ax = (op == MULH || op == MULHSU) ? {{`MD_XLEN{a[`MD_XLEN-1]}}, a} : dword_t'(a);
		bx = (op == MULH) ? {{`MD_XLEN{b[`MD_XLEN-1]}}, b} : dword_t'(b);
		prod = ax * bx;
		sa = (op == DIV || op == REM) ? longint'(signed'(a)) : longint'(dword_t'(a));
		sb = (op == DIV || op == REM) ? longint'(signed'(b)) : longint'(dword_t'(b));
		case (op)
			MUL: return prod[`MD_XLEN-1:0];
			MULH, MULHSU, MULHU: return prod[2*`MD_XLEN-1:`MD_XLEN];
			DIV, DIVU: return (b == '0) ? '1 : xlen_t'(sa / sb);
			REM, REMU: return (b == '0) ? a : xlen_t'(sa % sb);
			default: return '0;
		endcase
	endfunction

	task automatic check_product(input md_op_e op, input xlen_t exp_v, input xlen_t act_v);
		if (act_v !== exp_v) begin
			stop_with_fail($sformatf("error at %0d ns: %s product expected %h, got %h",
				$time, op.name(), exp_v, act_v));
		end
	endtask

	task automatic check_divide(input md_op_e op, input xlen_t exp_v, input xlen_t act_v);
		if (act_v !== exp_v) begin
			stop_with_fail($sformatf("error at %0d ns: %s result expected %h, got %h",
				$time, op.name(), exp_v, act_v));
		end
	endtask

	task automatic check_latency(input md_op_e op, input int exp_c, input int act_c);
		if (act_c != exp_c) begin
			stop_with_fail($sformatf("error at %0d ns: %s latency expected %0d, got %0d cycles",
				$time, op.name(), exp_c, act_c));
		end
	endtask

	// compare on the falling edge where outputs are settled
	always @(negedge clk_i) begin
		if (!rst_i && done_o) begin
			if (exp_q.size() == 0) begin
				stop_with_fail("done_o pulsed while no request was pending");
			end else begin
				chk_item = exp_q.pop_front();
				if (chk_item.op[2]) begin
					check_divide(chk_item.op, chk_item.val, result_o);
					check_latency(chk_item.op, DIV_LAT, cyc_cnt - chk_item.t0);
				end else begin
					check_product(chk_item.op, chk_item.val, result_o);
					check_latency(chk_item.op, MUL_LAT, cyc_cnt - chk_item.t0);
				end
			end
		end
	end

	// hold req until done, then one idle cycle
	task automatic run_req(input md_op_e op, input xlen_t a, input xlen_t b);
		exp_t item;
		item.op  = op;
		item.val = ref_muldiv(op, a, b);
		item.t0  = cyc_cnt;
		exp_q.push_back(item);
		req_data_i.op  = op;
		req_data_i.rs1 = a;
		req_data_i.rs2 = b;
		req_i = 1'b1;
		do begin
			@(negedge clk_i);
		end while (!done_o);
		@(posedge clk_i);
		#DRIVE_DLY;
		req_i = 1'b0;
		@(posedge clk_i);
		#DRIVE_DLY;
	endtask

	// abandoned request without a done
	task automatic drop_req(input md_op_e op, input xlen_t a, input xlen_t b);
		req_data_i.op  = op;
		req_data_i.rs1 = a;
		req_data_i.rs2 = b;
		req_i = 1'b1;
		repeat (10) @(posedge clk_i);
		#DRIVE_DLY;
		req_i = 1'b0;
		repeat (30) @(posedge clk_i); // past the divider's own finish
		#DRIVE_DLY;
	endtask

	initial begin
		xlen_t a;
		xlen_t b;
		xlen_t op_bits;
		xlen_t shamt;
		xlen_t shrink;
		lfsr_q     = 16'd20039;
		clk_i      = 1'b0;
		rst_i      = 1'b1;
		req_i      = 1'b0;
		req_data_i = '0;
		repeat (8) @(posedge clk_i);
		#DRIVE_DLY;
		rst_i = 1'b0;
		repeat (10) @(posedge clk_i); // idle stretch before the first request
		#DRIVE_DLY;

		// zero divisor
		a = rand_bits(`MD_XLEN);
		run_req(DIV, a, '0);
		run_req(DIVU, a, '0);
		run_req(REM, a, '0);
		run_req(REMU, a, '0);

		// signed overflow
		run_req(DIV, 32'h8000_0000, '1);
		run_req(REM, 32'h8000_0000, '1);

		// mixed signs
		run_req(DIV, xlen_t'(-7), 32'd2);
		run_req(REM, xlen_t'(-7), 32'd2);
		run_req(DIV, 32'd7, xlen_t'(-2));
		run_req(REM, 32'd7, xlen_t'(-2));

		drop_req(DIV, rand_bits(`MD_XLEN), rand_bits(`MD_XLEN));
		run_req(MULH, rand_bits(`MD_XLEN), rand_bits(`MD_XLEN));

		for (int i = 0; i < N_RANDOM; i++) begin
			op_bits = rand_bits(3);
			a       = rand_bits(`MD_XLEN);
			b       = rand_bits(`MD_XLEN);
			shamt   = rand_bits(5);
			shrink  = rand_bits(1);
			if (op_bits[2] && shrink[0]) begin
				b = xlen_t'($signed(b) >>> shamt[4:0]); // smaller divisor with its sign kept
			end
			run_req(md_op_e'(op_bits[2:0]), a, b);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== sim/muldiv_props.sv ====
// handshake and latency properties, bound to muldiv_ctrl
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_props
	import muldiv_op_pkg::*;
(
	input logic        clk_i,
	input logic        rst_i,
	input logic        req_i,
	input logic        done_i,
	input logic        div_start_i,
	input logic        mul_start_i,
	input ctrl_state_e state_i
);

	// done is a one-cycle strobe
	done_single: assert property (@(posedge clk_i) disable iff (rst_i)
		done_i |=> !done_i)
		else $error("done held for more than one cycle");

	// starts only come out of IDLE
	start_from_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		(div_start_i || mul_start_i) |-> $past(state_i) == IDLE)
		else $error("unit started while a request was in service");

	done_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
		done_i |-> req_i)
		else $error("done without a request");

	// unit latency plus the result register
	done_latency: assert property (@(posedge clk_i) disable iff (rst_i)
		done_i |-> ($past(mul_start_i, `MD_MUL_LAT + 1) || $past(div_start_i, `MD_DIV_STEPS + 3)))
		else $error("done at an unexpected distance from start");

endmodule

bind muldiv_ctrl muldiv_props muldiv_props_i (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.req_i       (req_i),
	.done_i      (done_o),
	.div_start_i (div_start_o),
	.mul_start_i (mul_start_o),
	.state_i     (state_q)
);

// ==== source/muldiv_top.sv ====
// top level connecting controller, divider and multiplier
`timescale 1ns/1ps

module muldiv_top
	import muldiv_types_pkg::*;
	import muldiv_op_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    req_i,
	input  md_req_t req_data_i,
	output logic    done_o,
	output xlen_t   result_o
);

	md_req_t unit_req;
	logic    div_start;
	logic    mul_start;
	logic    div_valid;
	logic    mul_valid;
	xlen_t   div_res;
	xlen_t   mul_res;

	muldiv_ctrl muldiv_ctrl_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_i       (req_i),
		.req_data_i  (req_data_i),
		.div_valid_i (div_valid),
		.div_res_i   (div_res),
		.mul_valid_i (mul_valid),
		.mul_res_i   (mul_res),
		.div_start_o (div_start),
		.mul_start_o (mul_start),
		.unit_req_o  (unit_req),
		.done_o      (done_o),
		.result_o    (result_o)
	);

	div_unit div_unit_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.start_i    (div_start),
		.req_i      (unit_req),
		.valid_o    (div_valid),
		.quot_rem_o (div_res)
	);

	mul_unit mul_unit_i (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.start_i (mul_start),
		.req_i   (unit_req),
		.valid_o (mul_valid),
		.prod_o  (mul_res)
	);

endmodule

// ==== source/muldiv_ctrl.sv ====
// request tracker dispatching to multiplier or divider, with result register and done strobe
`timescale 1ns/1ps

module muldiv_ctrl
	import muldiv_types_pkg::*;
	import muldiv_op_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    req_i,
	input  md_req_t req_data_i,
	input  logic    div_valid_i,
	input  xlen_t   div_res_i,
	input  logic    mul_valid_i,
	input  xlen_t   mul_res_i,
	output logic    div_start_o,
	output logic    mul_start_o,
	output md_req_t unit_req_o,
	output logic    done_o,
	output xlen_t   result_o
);

	ctrl_state_e state_q;
	logic        req_prev_q;
	logic        is_div_q;   // unit serving the current request

	logic        launch;
	logic        accept;
	logic        unit_valid;
	xlen_t       unit_res;

	assign unit_valid = is_div_q ? div_valid_i : mul_valid_i;
	assign unit_res   = is_div_q ? div_res_i : mul_res_i;

	assign launch = (state_q == IDLE) && req_i && !req_prev_q; // rising edge of req
	assign accept = (state_q == BUSY) && req_i && unit_valid;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q     <= IDLE;
			req_prev_q  <= 1'b0;
			is_div_q    <= 1'b0;
			div_start_o <= 1'b0;
			mul_start_o <= 1'b0;
			done_o      <= 1'b0;
		end else begin
			req_prev_q  <= req_i;
			div_start_o <= 1'b0;
			mul_start_o <= 1'b0;
			done_o      <= 1'b0;
			case (state_q)
				IDLE: begin
					if (launch) begin
						is_div_q    <= req_data_i.op[2];
						div_start_o <= req_data_i.op[2];
						mul_start_o <= ~req_data_i.op[2];
						state_q     <= BUSY;
					end
				end
				BUSY: begin
					if (!req_i) begin
						state_q <= IDLE; // abandoned, late valid is ignored
					end else if (accept) begin
						done_o  <= 1'b1;
						state_q <= DRAIN;
					end
				end
				DRAIN: begin
					if (!req_i) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (launch) begin
			unit_req_o <= req_data_i;
		end
		if (accept) begin
			result_o <= unit_res; // held until the next done
		end
	end

endmodule

// ==== source/mul_unit.sv ====
// two-stage multiplier returning the low or high product word for MUL, MULH, MULHSU, MULHU
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module mul_unit
	import muldiv_types_pkg::*;
	import muldiv_op_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    start_i,
	input  md_req_t req_i,
	output logic    valid_o,
	output xlen_t   prod_o
);

	md_op_e                      op1_q;
	logic signed [`MD_XLEN:0]    a_q;
	logic signed [`MD_XLEN:0]    b_q;
	logic [`MD_MUL_LAT-1:0]      vld_q;

	logic                        a_sgn;
	logic                        b_sgn;
	logic signed [2*`MD_XLEN+1:0] prod_full;
	dword_t                      prod_w;

	// rs1 is signed for MULH and MULHSU, rs2 only for MULH
	assign a_sgn = (req_i.op == MULH) || (req_i.op == MULHSU);
	assign b_sgn = (req_i.op == MULH);

	// 33x33 signed covers every sign mix
	assign prod_full = a_q * b_q;
	assign prod_w    = prod_full[2*`MD_XLEN-1:0];

	assign valid_o = vld_q[`MD_MUL_LAT-1];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[`MD_MUL_LAT-2:0], start_i};
		end
	end

	// stage 1, extended operands
	always_ff @(posedge clk_i) begin
		if (start_i) begin
			a_q   <= {a_sgn & req_i.rs1[`MD_XLEN-1], req_i.rs1};
			b_q   <= {b_sgn & req_i.rs2[`MD_XLEN-1], req_i.rs2};
			op1_q <= req_i.op;
		end
	end

	// stage 2, product and word select
	always_ff @(posedge clk_i) begin
		if (vld_q[0]) begin
			if (op1_q == MUL) begin
				prod_o <= prod_w[`MD_XLEN-1:0];
			end else begin
				prod_o <= prod_w[2*`MD_XLEN-1:`MD_XLEN];
			end
		end
	end

endmodule

// ==== source/div_unit.sv ====
// restoring divider for DIV, DIVU, REM and REMU with zero-divisor handling
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module div_unit
	import muldiv_types_pkg::*;
	import muldiv_op_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    start_i,
	input  md_req_t req_i,
	output logic    valid_o,
	output xlen_t   quot_rem_o
);

	md_op_e op_q;
	logic   neg_dvd_q;
	logic   neg_dvs_q;
	logic   zero_q;
	xlen_t  dvd_q;  // raw dividend, returned as remainder on zero divisor
	xlen_t  quo_q;  // dividend shifts out, quotient shifts in
	dwork_t rem_q;
	dwork_t dvs_q;
	dstep_t step_q;

	logic   sgn_op;
	xlen_t  rs1_mag;
	xlen_t  rs2_mag;
	dwork_t trial;
	logic   borrow;
	xlen_t  quo_fix;
	xlen_t  rem_fix;
	xlen_t  fin_res;

	// bit 0 of the div ops marks unsigned
	assign sgn_op  = ~req_i.op[0];
	assign rs1_mag = (sgn_op && req_i.rs1[`MD_XLEN-1]) ? -req_i.rs1 : req_i.rs1;
	assign rs2_mag = (sgn_op && req_i.rs2[`MD_XLEN-1]) ? -req_i.rs2 : req_i.rs2;

	// shift next dividend bit in and try the subtraction
	assign trial  = {rem_q[`MD_XLEN-1:0], quo_q[`MD_XLEN-1]} - dvs_q;
	assign borrow = trial[`MD_XLEN];

	assign quo_fix = (neg_dvd_q ^ neg_dvs_q) ? -quo_q : quo_q;
	assign rem_fix = neg_dvd_q ? -rem_q[`MD_XLEN-1:0] : rem_q[`MD_XLEN-1:0];

	always_comb begin
		if (zero_q) begin
			fin_res = op_q[1] ? dvd_q : '1; // rem keeps dividend, div gives all ones
		end else begin
			fin_res = op_q[1] ? rem_fix : quo_fix;
		end
	end

	// step counter and valid
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			step_q  <= '0;
			valid_o <= 1'b0;
		end else begin
			// a restart drops the result of the old run
			valid_o <= step_q[`MD_DIV_STEPS] & ~start_i;
			if (start_i) begin
				step_q <= dstep_t'(1);
			end else begin
				step_q <= step_q << 1; // finish bit falls off the top
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i) begin
			op_q      <= req_i.op;
			neg_dvd_q <= sgn_op & req_i.rs1[`MD_XLEN-1];
			neg_dvs_q <= sgn_op & req_i.rs2[`MD_XLEN-1];
			zero_q    <= (req_i.rs2 == '0);
			dvd_q     <= req_i.rs1;
			quo_q     <= rs1_mag;
			rem_q     <= '0;
			dvs_q     <= {1'b0, rs2_mag};
		end else if (|step_q[`MD_DIV_STEPS-1:0]) begin
			quo_q <= {quo_q[`MD_XLEN-2:0], ~borrow};
			if (borrow) begin
				rem_q <= {rem_q[`MD_XLEN-1:0], quo_q[`MD_XLEN-1]}; // restore
			end else begin
				rem_q <= trial;
			end
		end else if (step_q[`MD_DIV_STEPS]) begin
			quot_rem_o <= fin_res;
		end
	end

endmodule

// ==== source/muldiv_op_pkg.sv ====
// operation enum, request struct and controller state enum
package muldiv_op_pkg;

	import muldiv_types_pkg::*;

	// funct3 order, bit 2 selects division
	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} md_op_e;

	typedef struct packed {
		md_op_e op;
		xlen_t  rs1;
		xlen_t  rs2;
	} md_req_t;

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		DRAIN // result given, waiting for req to drop
	} ctrl_state_e;

endpackage

// ==== source/muldiv_types_pkg.sv ====
// data width typedefs for operand words, products and divider working vectors
`include "muldiv_defines.svh"

package muldiv_types_pkg;

	// operand or result word
	typedef logic [`MD_XLEN-1:0] xlen_t;

	// full product of two words
	typedef logic [2*`MD_XLEN-1:0] dword_t;

	// remainder with borrow bit
	typedef logic [`MD_XLEN:0] dwork_t;

	// one-hot divider step counter, top bit is the finish cycle
	typedef logic [`MD_DIV_STEPS:0] dstep_t;

endpackage

// ==== include/muldiv_defines.svh ====
// word width, divider step count and multiplier latency of the M-extension unit
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// RV32 only, the funct3 encoding and overflow rules assume 32 bits
`define MD_XLEN 32

// one quotient bit per step
`define MD_DIV_STEPS 32

// start to valid, operand stage plus product stage
`define MD_MUL_LAT 2

`endif
